/* design/dc_fifo_input_data_info.sv */
`include "info_macros.svh"

module dc_fifo_input_data_info #(
    parameter int DATA_BIT   = `INFO_REC_BIT,
    parameter int DATA_DEPTH = `INFO_DEPTH_BIT
) (
    input  logic                  rst_n,

    input  logic                  wr_clk,
    input  logic [DATA_BIT-1:0]   wr_data,
    input  logic                  wr_en,
    output logic [DATA_DEPTH-1:0] wr_cnt,

    input  logic                  rd_clk,
    output logic [DATA_BIT-1:0]   rd_data,
    input  logic                  rd_en,
    output logic [DATA_DEPTH-1:0] rd_cnt,

    output logic                  empty,
    output logic                  full
);

    localparam int ENTRIES = 2 ** DATA_DEPTH;

    logic [DATA_BIT-1:0]   mem [ENTRIES];

    // Write side pointers with one extra wrap bit
    logic [DATA_DEPTH:0]   w_ptr;
    logic [DATA_DEPTH:0]   w_ptr_gray;
    logic [DATA_DEPTH:0]   w_gray_s1;
    logic [DATA_DEPTH:0]   w_gray_s2;
    logic [DATA_DEPTH:0]   w_ptr_sync;       // Write pointer seen by read side

    // Read side pointers
    logic [DATA_DEPTH:0]   r_ptr;
    logic [DATA_DEPTH:0]   r_ptr_gray;
    logic [DATA_DEPTH:0]   r_gray_s1;
    logic [DATA_DEPTH:0]   r_gray_s2;
    logic [DATA_DEPTH:0]   r_ptr_sync;       // Read pointer seen by write side

    logic                  wr_take;
    logic                  rd_take;

    assign wr_take = wr_en && !full;
    assign rd_take = rd_en && !empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge wr_clk) begin
        if (wr_take) begin
            mem[w_ptr[DATA_DEPTH-1:0]] <= wr_data;
        end
    end

    assign rd_data = mem[r_ptr[DATA_DEPTH-1:0]];   // Show-ahead head entry

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write clock domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign w_ptr_gray = (w_ptr >> 1) ^ w_ptr;

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_ptr <= '0;
        end else if (wr_take) begin
            w_ptr <= w_ptr + 1'b1;
        end
    end

    // Read pointer crosses in through two flops
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            r_gray_s1 <= '0;
            r_gray_s2 <= '0;
        end else begin
            r_gray_s1 <= r_ptr_gray;
            r_gray_s2 <= r_gray_s1;
        end
    end

    // Binary bit i is the XOR of Gray bits i and up
    for (genvar i = 0; i <= DATA_DEPTH; i++) begin : g_r_gray2bin
        assign r_ptr_sync[i] = ^r_gray_s2[DATA_DEPTH:i];
    end

    // Full when the top two Gray bits differ and the rest match
    assign full = (w_ptr_gray[DATA_DEPTH]   != r_gray_s2[DATA_DEPTH]) &&
                  (w_ptr_gray[DATA_DEPTH-1] != r_gray_s2[DATA_DEPTH-1]) &&
                  (w_ptr_gray[DATA_DEPTH-2:0] == r_gray_s2[DATA_DEPTH-2:0]);

    // Fill count wraps to 0 at ENTRIES
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else begin
            wr_cnt <= w_ptr[DATA_DEPTH-1:0] - r_ptr_sync[DATA_DEPTH-1:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read clock domain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign r_ptr_gray = (r_ptr >> 1) ^ r_ptr;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            r_ptr <= '0;
        end else if (rd_take) begin
            r_ptr <= r_ptr + 1'b1;
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_gray_s1 <= '0;
            w_gray_s2 <= '0;
        end else begin
            w_gray_s1 <= w_ptr_gray;
            w_gray_s2 <= w_gray_s1;
        end
    end

    for (genvar j = 0; j <= DATA_DEPTH; j++) begin : g_w_gray2bin
        assign w_ptr_sync[j] = ^w_gray_s2[DATA_DEPTH:j];
    end

    assign empty = (r_ptr_gray == w_gray_s2);   // Pointers equal incl. wrap bit

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
        end else begin
            rd_cnt <= w_ptr_sync[DATA_DEPTH-1:0] - r_ptr[DATA_DEPTH-1:0];
        end
    end

endmodule

/* design/info_capture.sv */
`include "info_macros.svh"

module info_capture (
    input  logic                         wr_clk,
    input  logic                         rst_n,
    input  logic                         in_strobe,
    input  logic [`INFO_KIND_BIT-1:0]    in_kind,
    input  logic [`INFO_PAYLOAD_BIT-1:0] in_payload,
    input  logic                         full,
    output logic                         fifo_wr_en,
    output logic [`INFO_REC_BIT-1:0]     fifo_wr_data,
    output logic [15:0]                  drop_cnt,
    output logic [15:0]                  bad_cnt
);

    logic [`INFO_STAMP_BIT-1:0] stamp_cnt;
    logic                       kind_bad;

    // Codes past the last enum value are illegal
    assign kind_bad = in_kind > info_pkg::KIND_LAST;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Free-running stamp and write strobe
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            stamp_cnt  <= '0;
            fifo_wr_en <= 1'b0;
        end else begin
            stamp_cnt  <= stamp_cnt + 1'b1;           // Wraps silently
            fifo_wr_en <= in_strobe && !kind_bad;
        end
    end

    // Record register, loaded on every legal strobe
    always_ff @(posedge wr_clk) begin
        if (in_strobe && !kind_bad) begin
            fifo_wr_data <= {in_kind, stamp_cnt, in_payload};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drop and reject counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_cnt <= '0;
            bad_cnt  <= '0;
        end else begin
            if (fifo_wr_en && full) begin
                drop_cnt <= drop_cnt + 1'b1;          // FIFO refused this write
            end
            if (in_strobe && kind_bad) begin
                bad_cnt <= bad_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/info_macros.svh */
`ifndef INFO_MACROS_SVH
`define INFO_MACROS_SVH

// Record layout, MSB first: kind | stamp | payload
`define INFO_KIND_BIT     3
`define INFO_STAMP_BIT    12
`define INFO_PAYLOAD_BIT  32
`define INFO_REC_BIT      47

// Field positions inside one record
`define INFO_PAYLOAD_LSB  0
`define INFO_STAMP_LSB    32
`define INFO_KIND_LSB     44

// FIFO depth as address bits, 2**5 = 32 entries
`define INFO_DEPTH_BIT    5

`endif

/* design/info_path_top.sv */
`include "info_macros.svh"

module info_path_top (
    input  logic                         wr_clk,
    input  logic                         rd_clk,
    input  logic                         rst_n,
    input  logic                         in_strobe,
    input  logic [`INFO_KIND_BIT-1:0]    in_kind,
    input  logic [`INFO_PAYLOAD_BIT-1:0] in_payload,
    input  logic                         out_stall,
    output logic                         out_valid,
    output info_pkg::rec_kind_e          out_kind,
    output logic [`INFO_STAMP_BIT-1:0]   out_stamp,
    output logic [`INFO_PAYLOAD_BIT-1:0] out_payload,
    output logic [15:0]                  drop_cnt,
    output logic [15:0]                  bad_cnt,
    output logic                         full,
    output logic [`INFO_DEPTH_BIT-1:0]   wr_level
);

    logic                     fifo_wr_en;
    logic [`INFO_REC_BIT-1:0] fifo_wr_data;
    logic [`INFO_REC_BIT-1:0] rd_data;
    logic                     rd_en;
    logic                     empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wr_clk side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    info_capture u_capture (
        .wr_clk       (wr_clk),
        .rst_n        (rst_n),
        .in_strobe    (in_strobe),
        .in_kind      (in_kind),
        .in_payload   (in_payload),
        .full         (full),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .drop_cnt     (drop_cnt),
        .bad_cnt      (bad_cnt)
    );

    // Clock crossing
    dc_fifo_input_data_info #(
        .DATA_BIT   (`INFO_REC_BIT),
        .DATA_DEPTH (`INFO_DEPTH_BIT)
    ) u_fifo (
        .rst_n   (rst_n),
        .wr_clk  (wr_clk),
        .wr_data (fifo_wr_data),
        .wr_en   (fifo_wr_en),
        .wr_cnt  (wr_level),         // Reads 0 when all 32 entries are used
        .rd_clk  (rd_clk),
        .rd_data (rd_data),
        .rd_en   (rd_en),
        .rd_cnt  (),
        .empty   (empty),
        .full    (full)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rd_clk side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    info_unpack u_unpack (
        .rd_clk      (rd_clk),
        .rst_n       (rst_n),
        .rd_data     (rd_data),
        .empty       (empty),
        .out_stall   (out_stall),
        .rd_en       (rd_en),
        .out_valid   (out_valid),
        .out_kind    (out_kind),
        .out_stamp   (out_stamp),
        .out_payload (out_payload)
    );

endmodule

/* design/info_pkg.sv */
`include "info_macros.svh"

package info_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Record kind opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [`INFO_KIND_BIT-1:0] {
        KIND_SAMPLE = 0,  // Plain data sample
        KIND_MARK   = 1,  // Time marker
        KIND_STATUS = 2,
        KIND_ALARM  = 3,
        KIND_CONFIG = 4   // Configuration echo
    } rec_kind_e;

    // Highest legal code, 5 to 7 get rejected at capture
    localparam rec_kind_e KIND_LAST = KIND_CONFIG;

endpackage

/* design/info_unpack.sv */
`include "info_macros.svh"

module info_unpack (
    input  logic                         rd_clk,
    input  logic                         rst_n,
    input  logic [`INFO_REC_BIT-1:0]     rd_data,
    input  logic                         empty,
    input  logic                         out_stall,
    output logic                         rd_en,
    output logic                         out_valid,
    output info_pkg::rec_kind_e          out_kind,
    output logic [`INFO_STAMP_BIT-1:0]   out_stamp,
    output logic [`INFO_PAYLOAD_BIT-1:0] out_payload
);

    logic [`INFO_KIND_BIT-1:0]    head_kind;
    logic [`INFO_STAMP_BIT-1:0]   head_stamp;
    logic [`INFO_PAYLOAD_BIT-1:0] head_payload;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field split of the show-ahead head
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign head_kind    = rd_data[`INFO_KIND_LSB +: `INFO_KIND_BIT];
    assign head_stamp   = rd_data[`INFO_STAMP_LSB +: `INFO_STAMP_BIT];
    assign head_payload = rd_data[`INFO_PAYLOAD_LSB +: `INFO_PAYLOAD_BIT];

    // Pop whenever something is there and nobody stalls
    assign rd_en = !empty && !out_stall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stage, one cycle behind the pop
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;                       // One pulse per popped record
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            out_kind    <= info_pkg::rec_kind_e'(head_kind);
            out_stamp   <= head_stamp;
            out_payload <= head_payload;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the info path testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
    -f src.f --top-module info_tb -o info_sim > build.log 2>&1 \
    && ./obj_dir/info_sim > sim.log 2>&1 \
    || { cat build.log; cat sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }

grep -qx "Test completed successfully" sim.log \
    && { echo "PASS"; exit 0; } \
    || { tail -n 20 sim.log; echo "FAIL"; exit 1; }

/* src.f */
+incdir+design
design/info_pkg.sv
design/info_capture.sv
design/dc_fifo_input_data_info.sv
design/info_unpack.sv
design/info_path_top.sv
verif/info_clk_gen.sv
verif/info_assert.sv
verif/info_tb.sv

/* verif/info_assert.sv */
`include "info_macros.svh"

module info_assert (
    input logic                      wr_clk,
    input logic                      rd_clk,
    input logic                      rst_n,
    input logic                      full,
    input logic [15:0]               drop_cnt,
    input logic                      out_stall,
    input logic                      out_valid,
    input logic                      in_strobe,
    input logic [`INFO_KIND_BIT-1:0] in_kind,
    input logic                      fifo_wr_en
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_drop_only_when_full : assert property (
        @(posedge wr_clk) disable iff (!rst_n)
        (drop_cnt != $past(drop_cnt)) |-> $past(full)
    ) else $error("drop_cnt changed while the FIFO was not full");

    // An illegal strobe must not turn into a write one cycle later
    a_no_write_for_bad_kind : assert property (
        @(posedge wr_clk) disable iff (!rst_n)
        (in_strobe && (in_kind > info_pkg::KIND_LAST)) |=> !fifo_wr_en
    ) else $error("FIFO write enable followed a strobe with an illegal record kind");

    // A stalled read cycle pops nothing
    a_no_valid_after_stall : assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        out_stall |=> !out_valid
    ) else $error("out_valid followed a cycle with out_stall high");

endmodule

bind info_path_top info_assert u_assert (
    .wr_clk     (wr_clk),
    .rd_clk     (rd_clk),
    .rst_n      (rst_n),
    .full       (full),
    .drop_cnt   (drop_cnt),
    .out_stall  (out_stall),
    .out_valid  (out_valid),
    .in_strobe  (in_strobe),
    .in_kind    (in_kind),
    .fifo_wr_en (fifo_wr_en)
);

/* verif/info_clk_gen.sv */
module info_clk_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                          // Low at time zero
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

/* verif/info_tb.sv */
`include "info_macros.svh"

module info_tb;

    logic                         wr_clk;
    logic                         rd_clk;
    logic                         rst_n;
    logic                         in_strobe;
    logic [`INFO_KIND_BIT-1:0]    in_kind;
    logic [`INFO_PAYLOAD_BIT-1:0] in_payload;
    logic                         out_stall;
    logic                         out_valid;
    info_pkg::rec_kind_e          out_kind;
    logic [`INFO_STAMP_BIT-1:0]   out_stamp;
    logic [`INFO_PAYLOAD_BIT-1:0] out_payload;
    logic [15:0]                  drop_cnt;
    logic [15:0]                  bad_cnt;
    logic                         full;
    logic [`INFO_DEPTH_BIT-1:0]   wr_level;

    logic [`INFO_REC_BIT-1:0]     exp_q [$];         // Records the DUT still owes
    logic [`INFO_REC_BIT-1:0]     exp_rec;
    logic [31:0]                  wr_cycle = '0;     // wr_clk edges since reset release
    logic [31:0]                  rng_state = 32'd32;
    string                        steps [$];
    int unsigned                  limit = 0;
    int                           file_lines = 0;
    int                           rx_count = 0;
    int                           check_count = 0;
    int                           value_errors = 0;
    int                           other_errors = 0;

    info_clk_gen #(.HALF_PERIOD(2)) u_wr_clk_gen (.clk(wr_clk));
    info_clk_gen #(.HALF_PERIOD(3)) u_rd_clk_gen (.clk(rd_clk));

    info_path_top u_dut (
        .wr_clk      (wr_clk),
        .rd_clk      (rd_clk),
        .rst_n       (rst_n),
        .in_strobe   (in_strobe),
        .in_kind     (in_kind),
        .in_payload  (in_payload),
        .out_stall   (out_stall),
        .out_valid   (out_valid),
        .out_kind    (out_kind),
        .out_stamp   (out_stamp),
        .out_payload (out_payload),
        .drop_cnt    (drop_cnt),
        .bad_cnt     (bad_cnt),
        .full        (full),
        .wr_level    (wr_level)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic release_strobe();
        if (in_strobe) begin
            @(negedge wr_clk);
            in_strobe = 1'b0;
        end
    endtask

    task automatic send_records(input int count, input logic [2:0] kind, input bit use_rand,
                                input logic [31:0] fixed_pay, input bit deliver, input int gap);
        logic [31:0] pay;
        for (int i = 0; i < count; i++) begin
            @(negedge wr_clk);
            if (use_rand) begin
                rng_state = xorshift32(rng_state);
                pay = rng_state;
            end else begin
                pay = fixed_pay;
            end
            in_strobe  = 1'b1;
            in_kind    = kind;
            in_payload = pay;
            if (deliver) begin
                // Next edge samples the stamp counter at wr_cycle
                exp_q.push_back({kind, wr_cycle[`INFO_STAMP_BIT-1:0], pay});
            end
        end
        if (gap > 0) begin
            @(negedge wr_clk);
            in_strobe = 1'b0;
            repeat (gap - 1) @(negedge wr_clk);
        end
    endtask

    task automatic drain_and_count(input int expected);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 500) begin
            @(posedge rd_clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Drain gave up with %0d expected records never received", exp_q.size());
            exp_q.delete();
        end
        repeat (10) @(posedge rd_clk);                // Room for stray records
        check_value("rx_count", 64'(rx_count), 64'(expected));
        rx_count = 0;
    endtask

    task automatic run_step(input string line);
        string       op;
        string       pay_tok;
        int          n;
        int          count;
        int          fate;
        int          gap;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] pay_val;
        pay_val = '0;
        n = $sscanf(line, "%s", op);
        if (op != "W") release_strobe();
        if (op == "W") begin
            n = $sscanf(line, "%s %d %h %s %d %d", op, count, a, pay_tok, fate, gap);
            if (n == 6 && pay_tok != "R") n = 5 + $sscanf(pay_tok, "%h", pay_val);
            if (n == 6) send_records(count, a[2:0], pay_tok == "R", pay_val, fate != 0, gap);
        end else if (op == "S") begin
            n = $sscanf(line, "%s %h", op, a) + 4;
            @(negedge rd_clk);
            out_stall = a[0];
        end else if (op == "D") begin
            n = $sscanf(line, "%s %d", op, count) + 4;
            if (n == 6) drain_and_count(count);
        end else if (op == "C") begin
            n = $sscanf(line, "%s %h %h %h %h", op, a, b, c, d) + 1;
            repeat (4) @(negedge wr_clk);             // Let write side flags settle
            check_value("drop_cnt", 64'(drop_cnt), 64'(a));
            check_value("bad_cnt", 64'(bad_cnt), 64'(b));
            check_value("full", 64'(full), 64'(c));
            check_value("wr_level", 64'(wr_level), 64'(d));
        end else begin
            n = 0;
        end
        if (n != 6) begin
            other_errors++;
            $display("Data file step could not be understood: %s", line);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stamp prediction and output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge wr_clk) begin
        if (rst_n) wr_cycle <= wr_cycle + 1;
    end

    always @(negedge rd_clk) begin
        if (rst_n && out_valid) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Unexpected record at the output, stamp 0x%0h", out_stamp);
            end else begin
                exp_rec = exp_q.pop_front();
                check_value("out_kind", 64'(out_kind),
                            64'(exp_rec[`INFO_KIND_LSB +: `INFO_KIND_BIT]));
                check_value("out_stamp", 64'(out_stamp),
                            64'(exp_rec[`INFO_STAMP_LSB +: `INFO_STAMP_BIT]));
                check_value("out_payload", 64'(out_payload),
                            64'(exp_rec[`INFO_PAYLOAD_LSB +: `INFO_PAYLOAD_BIT]));
            end
        end
    end

    initial begin
        wait (limit != 0);
        #(limit);
        $display("Watchdog expired after %0d time units before all steps finished", limit);
        $display("Test failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int    fd;
        string line;
        rst_n      = 1'b0;
        in_strobe  = 1'b0;
        in_kind    = '0;
        in_payload = '0;
        out_stall  = 1'b0;
        fd = $fopen("verif/info_testdata.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the data file verif/info_testdata.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                file_lines++;
                if (line.getc(0) != "#" && line.getc(0) != "\n") steps.push_back(line);
            end
            $fclose(fd);
            limit = file_lines * 400;
            repeat (2) @(posedge wr_clk);             // Reset held for 2 cycles
            @(negedge wr_clk);
            rst_n = 1'b1;
            check_value("out_valid", 64'(out_valid), 64'd0);
            foreach (steps[i]) run_step(steps[i]);
            release_strobe();
            drain_and_count(0);                       // Nothing may trail the last step
        end
        $display("Summary %0d checks, %0d value errors, %0d other errors",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verif/info_testdata.txt */
# W count kind(hex) payload(hex or R) delivered(1 or 0) idle_wr_cycles_after
# S stall(0 or 1) | D records_expected(dec) | C drop_cnt bad_cnt full wr_level (hex)
# Reset state
C 0 0 0 0
D 0
# Sparse single records
W 1 0 00000001 1 7
W 1 1 deadbeef 1 12
W 1 2 R 1 5
W 1 3 R 1 9
W 1 4 12345678 1 20
D 5
C 0 0 0 0
# Full-rate stream of 20
W 20 0 R 1 4
D 20
C 0 0 0 0
# Illegal kinds mixed with legal records
W 1 5 aaaa0005 0 0
W 1 1 R 1 0
W 1 6 aaaa0006 0 3
W 1 2 R 1 0
W 1 7 aaaa0007 0 0
W 2 4 R 1 6
D 4
C 0 3 0 0
# Back-pressure, 40 back-to-back with the reader stalled
S 1
W 32 3 R 1 0
W 8 3 R 0 6
C 8 3 1 0
S 0
D 32
C 8 3 0 0
# Stream resumes after the drops
W 3 0 R 1 2
D 3
C 8 3 0 0
